//--- hdl/api_pkg.sv
package api_pkg;

	typedef logic [31:0] word_t;
	typedef logic [27:0] timeout_t;
	typedef logic [7:0]  sck_div_t; // half period is sck_div + 1 clocks.
	typedef logic [5:0]  ch_num_t;
	typedef logic [7:0]  word_num_t;
	typedef logic [9:0]  fill_t;
	typedef logic [7:0]  axi_addr_t;

	// the host reads this encoding back in the state register.
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_WORK = 2'd1,
		ST_NOP  = 2'd2,
		ST_DONE = 2'd3
	} api_state_e;

	localparam axi_addr_t REG_STATE    = 8'h00;
	localparam axi_addr_t REG_TIMEOUT  = 8'h04;
	localparam axi_addr_t REG_SCK      = 8'h08;
	localparam axi_addr_t REG_CH_NUM   = 8'h0C;
	localparam axi_addr_t REG_WORD_NUM = 8'h10;
	localparam axi_addr_t REG_TX_DATA  = 8'h14;
	localparam axi_addr_t REG_RX_DATA  = 8'h18;
	localparam axi_addr_t REG_RX_COUNT = 8'h1C;

	localparam logic [7:0] TAG_BYTE = 8'h12; // marks the last word of a channel.

	typedef struct packed {
		timeout_t  timeout;
		sck_div_t  sck_div;
		ch_num_t   ch_num;
		word_num_t word_num;
	} api_cfg_s;

endpackage

//--- hdl/api_fifo.sv
`timescale 1ns/1ps

module api_fifo
	import api_pkg::*;
#(
	parameter int FIFO_DEPTH = 512
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  push,
	input  word_t din,
	input  logic  pop,
	output word_t dout,
	output logic  empty,
	output logic  full,
	output fill_t count
);
	localparam int AW = $clog2(FIFO_DEPTH);

	word_t         mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          wr_en;
	logic          rd_en;

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;
	assign empty = count == '0;
	assign full  = count == fill_t'(FIFO_DEPTH);
	assign dout  = mem[rd_ptr]; // head word shows without a pop.

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst) push |-> !full)
		else $error("push into a full fifo");
	assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
		else $error("pop from an empty fifo");

endmodule

//--- hdl/api_timer.sv
`timescale 1ns/1ps

module api_timer
	import api_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  timeout_t timeout,
	input  logic     start,
	output logic     busy
);
	timeout_t count;

	assign busy = count != '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (start) begin
			count <= timeout;
		end else if (busy) begin
			count <= count - 1'b1;
		end
	end

endmodule

//--- hdl/api_phy.sv
`timescale 1ns/1ps

module api_phy
	import api_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  sck_div_t sck_div,
	input  logic     start,
	input  word_t    tx_word,
	output logic     done,
	output word_t    rx_word,
	output logic     busy,
	output logic     sck,
	output logic     mosi,
	input  logic     miso
);
	sck_div_t   div_cnt;
	logic [5:0] half_cnt; // 64 half periods make one frame.
	logic       half_end;
	word_t      tx_sr;
	word_t      rx_sr;

	assign half_end = busy && div_cnt == sck_div;
	assign mosi     = tx_sr[31];
	assign rx_word  = rx_sr;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			done     <= 1'b0;
			sck      <= 1'b0;
			div_cnt  <= '0;
			half_cnt <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy     <= 1'b1;
				div_cnt  <= '0;
				half_cnt <= '0;
			end else if (busy) begin
				div_cnt <= half_end ? '0 : div_cnt + 1'b1;
				if (half_end) begin
					half_cnt <= half_cnt + 1'b1;
					sck      <= !half_cnt[0]; // even halves end in a rising edge.
					if (half_cnt == 6'd63) begin
						busy <= 1'b0;
						done <= 1'b1;
					end
				end
			end
		end
	end

	// the next bit goes out on the falling edge, so it is stable half a period early.
	// after the 32nd shift the register is empty and mosi rests low.
	always_ff @(posedge clk) begin
		if (rst) begin
			tx_sr <= '0;
		end else if (start) begin
			tx_sr <= tx_word;
		end else if (half_end && half_cnt[0]) begin
			tx_sr <= tx_sr << 1;
		end
	end

	always_ff @(posedge clk) begin
		if (half_end && !half_cnt[0]) begin
			rx_sr <= {rx_sr[30:0], miso}; // sampled as sck rises.
		end
	end

	assert property (@(posedge clk) disable iff (rst) start |-> !busy)
		else $error("frame started while the engine is busy");

endmodule

//--- hdl/api_regs.sv
`timescale 1ns/1ps

module api_regs
	import api_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  axi_addr_t  awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  word_t      wdata,
	input  logic       wvalid,
	output logic       wready,
	output logic [1:0] bresp,
	output logic       bvalid,
	input  logic       bready,
	input  axi_addr_t  araddr,
	input  logic       arvalid,
	output logic       arready,
	output word_t      rdata,
	output logic [1:0] rresp,
	output logic       rvalid,
	input  logic       rready,
	output api_cfg_s   cfg,
	input  api_state_e state,
	output logic       tx_push,
	output word_t      tx_data,
	input  logic       tx_full,
	input  word_t      rx_head,
	input  logic       rx_empty,
	input  fill_t      rx_count,
	output logic       rx_pop
);
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic  wr_hs;
	logic  rd_hs;
	logic  wr_err;
	logic  rd_err;
	word_t rd_data;

	// address and data are taken together and only one write is in flight.
	assign wr_hs   = awvalid && wvalid && !bvalid;
	assign awready = wr_hs;
	assign wready  = wr_hs;
	assign arready = !rvalid;
	assign rd_hs   = arvalid && arready;
	assign rx_pop  = rd_hs && araddr == REG_RX_DATA && !rx_empty;

	always_comb begin
		case (awaddr)
			REG_STATE, REG_RX_DATA, REG_RX_COUNT: wr_err = 1'b0; // writes here are ignored.
			REG_TIMEOUT, REG_SCK, REG_CH_NUM, REG_WORD_NUM: wr_err = 1'b0;
			REG_TX_DATA: wr_err = tx_full;
			default: wr_err = 1'b1;
		endcase
	end

	always_comb begin
		rd_data = '0;
		rd_err  = 1'b0;
		case (araddr)
			REG_STATE:    rd_data = word_t'(state);
			REG_TIMEOUT:  rd_data = word_t'(cfg.timeout);
			REG_SCK:      rd_data = word_t'(cfg.sck_div);
			REG_CH_NUM:   rd_data = word_t'(cfg.ch_num);
			REG_WORD_NUM: rd_data = word_t'(cfg.word_num);
			REG_TX_DATA:  rd_data = '0;
			REG_RX_DATA: begin
				if (rx_empty) begin
					rd_err = 1'b1;
				end else begin
					rd_data = rx_head;
				end
			end
			REG_RX_COUNT: rd_data = word_t'(rx_count);
			default:      rd_err = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg <= '0;
		end else if (wr_hs) begin
			case (awaddr)
				REG_TIMEOUT:  cfg.timeout  <= timeout_t'(wdata);
				REG_SCK:      cfg.sck_div  <= sck_div_t'(wdata);
				REG_CH_NUM:   cfg.ch_num   <= ch_num_t'(wdata);
				REG_WORD_NUM: cfg.word_num <= word_num_t'(wdata);
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid  <= 1'b0;
			tx_push <= 1'b0;
		end else begin
			tx_push <= wr_hs && awaddr == REG_TX_DATA && !tx_full;
			if (wr_hs) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hs) begin
			tx_data <= wdata;
			bresp   <= wr_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (rd_hs) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hs) begin
			rdata <= rd_data;
			rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	// a write response must stay up until the host takes it.
	assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

endmodule

//--- hdl/api_ctrl.sv
`timescale 1ns/1ps

module api_ctrl
	import api_pkg::*;
#(
	parameter int API_NUM    = 4,
	parameter int FIFO_DEPTH = 512
) (
	input  logic               clk,
	input  logic               rst,
	input  api_cfg_s           cfg,
	output api_state_e         state,
	input  word_t              tx_head,
	input  fill_t              tx_count,
	output logic               tx_pop,
	input  fill_t              rx_count,
	output logic               rx_push,
	output word_t              rx_data,
	output logic [API_NUM-1:0] load,
	output logic               sck,
	output logic               mosi,
	input  logic [API_NUM-1:0] miso
);
	localparam logic [API_NUM-1:0] SEL_ONE = API_NUM'(1);

	api_state_e nxt_state;
	ch_num_t    ch_cnt;
	ch_num_t    next_ch;
	word_num_t  word_cnt;
	logic [3:0] nop_cnt;
	logic       nop_done;
	logic       last_ch;
	logic       last_word;
	logic       can_start;
	logic       cfg_ok;
	logic       trail_done;
	logic       timer_start;
	logic       timer_busy;
	logic       phy_start;
	logic       phy_done;
	word_t      phy_rx;
	logic       miso_line;

	assign miso_line = &(miso | load); // unselected chips read as one.

	// a channel needs all of its words queued and room for all of its answers.
	assign can_start = fill_t'(cfg.word_num) <= tx_count &&
		fill_t'(cfg.word_num) <= fill_t'(FIFO_DEPTH) - rx_count;
	assign cfg_ok      = cfg.ch_num != '0 && cfg.word_num != '0;
	assign nop_done    = nop_cnt == 4'd14;
	assign last_ch     = ch_cnt == ch_num_t'(cfg.ch_num - 1'b1);
	assign last_word   = word_cnt == word_num_t'(cfg.word_num - 1'b1);
	assign next_ch     = (state == ST_IDLE) ? '0 : ch_num_t'(ch_cnt + 1'b1);
	assign timer_start = state == ST_IDLE && nxt_state != ST_IDLE;

	assign rx_push = state == ST_WORK && phy_done;
	assign tx_pop  = rx_push;
	assign rx_data = last_word ? {phy_rx[31:16], TAG_BYTE, 8'(ch_cnt)} : phy_rx;

	always_comb begin
		nxt_state = state;
		case (state)
			ST_IDLE: begin
				if (cfg_ok && can_start) begin
					nxt_state = ST_WORK;
				end
			end
			ST_WORK: begin
				if (phy_done && last_word) begin
					nxt_state = ST_NOP;
				end
			end
			ST_NOP: begin
				if (nop_done && last_ch) begin
					nxt_state = ST_DONE;
				end else if (nop_done && can_start) begin
					nxt_state = ST_WORK;
				end
			end
			ST_DONE: begin
				if (trail_done && !timer_busy) begin
					nxt_state = ST_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= ST_IDLE;
			ch_cnt     <= '0;
			word_cnt   <= '0;
			nop_cnt    <= '0;
			load       <= '1;
			phy_start  <= 1'b0;
			trail_done <= 1'b0;
		end else begin
			state      <= nxt_state;
			phy_start  <= 1'b0;
			trail_done <= state == ST_DONE && (trail_done || phy_done);
			if (state != ST_NOP) begin
				nop_cnt <= '0;
			end else if (!nop_done) begin
				nop_cnt <= nop_cnt + 1'b1; // holds at 14 while the next channel waits.
			end
			if (state != ST_WORK && nxt_state == ST_WORK) begin
				load      <= ~(SEL_ONE << next_ch);
				ch_cnt    <= next_ch;
				word_cnt  <= '0;
				phy_start <= 1'b1;
			end else if (state == ST_WORK && phy_done) begin
				word_cnt  <= word_cnt + 1'b1;
				phy_start <= !last_word;
			end else if (state == ST_NOP && nxt_state == ST_DONE) begin
				load      <= '1; // trailing frame goes out with nothing selected.
				phy_start <= 1'b1;
			end
		end
	end

	api_timer u_timer (
		.clk     (clk),
		.rst     (rst),
		.timeout (cfg.timeout),
		.start   (timer_start),
		.busy    (timer_busy)
	);

	api_phy u_phy (
		.clk     (clk),
		.rst     (rst),
		.sck_div (cfg.sck_div),
		.start   (phy_start),
		.tx_word (tx_head),
		.done    (phy_done),
		.rx_word (phy_rx),
		.busy    (),
		.sck     (sck),
		.mosi    (mosi),
		.miso    (miso_line)
	);

	// a chip is selected only while its channel runs or settles.
	assert property (@(posedge clk) disable iff (rst)
		$countones(~load) <= 1 && (load == '1 || state == ST_WORK || state == ST_NOP))
		else $error("chip selection does not match the sequencer state");
	assert property (@(posedge clk) disable iff (rst) tx_pop |-> tx_count != '0)
		else $error("transmit pop with no words queued");
	assert property (@(posedge clk) disable iff (rst) rx_push |-> rx_count != fill_t'(FIFO_DEPTH))
		else $error("receive push into a full fifo");

endmodule

//--- hdl/api_top.sv
`timescale 1ns/1ps

module api_top
	import api_pkg::*;
#(
	parameter int API_NUM    = 4,
	parameter int FIFO_DEPTH = 512
) (
	input  logic               clk,
	input  logic               rst,
	input  axi_addr_t          awaddr,
	input  logic               awvalid,
	output logic               awready,
	input  word_t              wdata,
	input  logic               wvalid,
	output logic               wready,
	output logic [1:0]         bresp,
	output logic               bvalid,
	input  logic               bready,
	input  axi_addr_t          araddr,
	input  logic               arvalid,
	output logic               arready,
	output word_t              rdata,
	output logic [1:0]         rresp,
	output logic               rvalid,
	input  logic               rready,
	output logic               sck,
	output logic               mosi,
	output logic [API_NUM-1:0] load,
	input  logic [API_NUM-1:0] miso
);
	api_cfg_s   cfg;
	api_state_e state;
	logic       tx_push;
	word_t      tx_data;
	logic       tx_full;
	logic       tx_pop;
	word_t      tx_head;
	fill_t      tx_count;
	logic       rx_push;
	word_t      rx_data;
	logic       rx_pop;
	word_t      rx_head;
	logic       rx_empty;
	fill_t      rx_count;

	api_regs u_regs (
		.clk (clk), .rst (rst),
		.awaddr (awaddr), .awvalid (awvalid), .awready (awready),
		.wdata (wdata), .wvalid (wvalid), .wready (wready),
		.bresp (bresp), .bvalid (bvalid), .bready (bready),
		.araddr (araddr), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
		.cfg (cfg), .state (state),
		.tx_push (tx_push), .tx_data (tx_data), .tx_full (tx_full),
		.rx_head (rx_head), .rx_empty (rx_empty), .rx_count (rx_count), .rx_pop (rx_pop)
	);

	api_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
		.clk (clk), .rst (rst),
		.push (tx_push), .din (tx_data), .pop (tx_pop), .dout (tx_head),
		.empty (), .full (tx_full), .count (tx_count)
	);

	api_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
		.clk (clk), .rst (rst),
		.push (rx_push), .din (rx_data), .pop (rx_pop), .dout (rx_head),
		.empty (rx_empty), .full (), .count (rx_count)
	);

	api_ctrl #(.API_NUM(API_NUM), .FIFO_DEPTH(FIFO_DEPTH)) u_ctrl (
		.clk (clk), .rst (rst),
		.cfg (cfg), .state (state),
		.tx_head (tx_head), .tx_count (tx_count), .tx_pop (tx_pop),
		.rx_count (rx_count), .rx_push (rx_push), .rx_data (rx_data),
		.load (load), .sck (sck), .mosi (mosi), .miso (miso)
	);

endmodule

//--- dv/api_chip_model.sv
`timescale 1ns/1ps

module api_chip_model
	import api_pkg::*;
#(
	parameter int API_NUM = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               sck,
	input  logic               mosi,
	input  logic [API_NUM-1:0] load,
	output logic [API_NUM-1:0] miso
);
	logic sck_q;
	logic sck_rise;

	assign sck_rise = sck && !sck_q;

	always_ff @(posedge clk) begin
		sck_q <= sck;
	end

	// each chip is a plain 32-bit shift register, so it answers with the word of its last frame.
	for (genvar i = 0; i < API_NUM; i++) begin : g_chip
		word_t sr;

		always_ff @(posedge clk) begin
			if (rst) begin
				sr <= '0;
			end else if (sck_rise && !load[i]) begin
				sr <= {sr[30:0], mosi}; // one clock after the host has sampled the old msb.
			end
		end

		assign miso[i] = load[i] ? 1'b1 : sr[31];
	end

endmodule

//--- dv/tb_api.sv
`timescale 1ns/1ps

module tb_api
	import api_pkg::*;
();
	localparam int API_NUM    = 4;
	localparam int FIFO_DEPTH = 512;
	localparam int CLK_HALF   = 10;
	localparam int RST_CYCLES = 16;
	localparam int HS_LIMIT   = 100;
	localparam int POLL_LIMIT = 50000;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	localparam int T2_CH  = 2;
	localparam int T2_WN  = 3;
	localparam int T2_DIV = 1;
	localparam int T2_TMO = 100;
	localparam int T4_CH  = 1;
	localparam int T4_WN  = 1;
	localparam int T4_DIV = 0;
	localparam int T4_TMO = 20000;
	localparam int T6_CH  = 3;
	localparam int T6_WN  = 2;
	localparam int T6_DIV = 2;
	localparam int T6_TMO = 50;

	// every transfer sends one trailing frame after its channel frames.
	localparam int WATCHDOG_CYCLES = 2 * (
		(T2_CH * T2_WN + 1) * 64 * (T2_DIV + 1) + T2_TMO +
		(T4_CH * T4_WN + 1) * 64 * (T4_DIV + 1) + T4_TMO +
		(T6_CH * T6_WN + 1) * 64 * (T6_DIV + 1) + T6_TMO);

	logic               clk;
	logic               rst;
	axi_addr_t          awaddr;
	logic               awvalid;
	logic               awready;
	word_t              wdata;
	logic               wvalid;
	logic               wready;
	logic [1:0]         bresp;
	logic               bvalid;
	logic               bready;
	axi_addr_t          araddr;
	logic               arvalid;
	logic               arready;
	word_t              rdata;
	logic [1:0]         rresp;
	logic               rvalid;
	logic               rready;
	logic               sck;
	logic               mosi;
	logic [API_NUM-1:0] load;
	logic [API_NUM-1:0] miso;

	int          errors = 0;
	int          checks = 0;
	int          cycle = 0;
	int          sel_mark = -1;
	logic [31:0] lfsr = 32'd72;
	word_t       chip_hist [API_NUM];

	api_top #(.API_NUM(API_NUM), .FIFO_DEPTH(FIFO_DEPTH)) i_api_top (
		.clk (clk), .rst (rst),
		.awaddr (awaddr), .awvalid (awvalid), .awready (awready),
		.wdata (wdata), .wvalid (wvalid), .wready (wready),
		.bresp (bresp), .bvalid (bvalid), .bready (bready),
		.araddr (araddr), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
		.sck (sck), .mosi (mosi), .load (load), .miso (miso)
	);

	api_chip_model #(.API_NUM(API_NUM)) u_chips (
		.clk (clk), .rst (rst), .sck (sck), .mosi (mosi), .load (load), .miso (miso)
	);

	initial clk = 1'b0;
	always #(CLK_HALF) clk = !clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// load is watched between edges, where it is stable.
	always @(negedge clk) begin
		if (!rst) begin
			if ($countones(~load) > 1) begin
				errors++;
				$display("FAIL load: 0x%h selects more than one chip at cycle %0d", load, cycle);
			end
			if (load != '1 && sel_mark < 0) begin
				sel_mark = cycle;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * 2 * CLK_HALF);
		$display("watchdog ran out after %0d cycles with the tests unfinished", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	function automatic word_t rand_word();
		word_t w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			w = {w[30:0], lfsr[0]};
		end
		return w;
	endfunction

	task automatic check_word(input string what, input word_t got, input word_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL %s: got 0x%08h, expected 0x%08h", what, got, want);
		end
	endtask

	task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL %s: got 0x%h, expected 0x%h", what, got, want);
		end
	endtask

	task automatic check_state(input string what, input api_state_e got, input api_state_e want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("FAIL %s: got 0x%h, expected 0x%h", what, got, want);
		end
	endtask

	task automatic axi_write(input axi_addr_t addr, input word_t data, output logic [1:0] resp);
		int waited;
		waited = 0;
		@(posedge clk);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		bready  <= 1'b1;
		do begin
			@(posedge clk);
			waited++;
		end while (!(awready && wready) && waited < HS_LIMIT);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		while (!bvalid && waited < HS_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		resp = bresp;
		bready <= 1'b0;
		if (waited >= HS_LIMIT) begin
			errors++;
			$display("write to address 0x%h was never completed", addr);
		end
	endtask

	task automatic axi_read(input axi_addr_t addr, output word_t data, output logic [1:0] resp);
		int waited;
		waited = 0;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= 1'b1;
		do begin
			@(posedge clk);
			waited++;
		end while (!arready && waited < HS_LIMIT);
		arvalid <= 1'b0;
		while (!rvalid && waited < HS_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
		if (waited >= HS_LIMIT) begin
			errors++;
			$display("read of address 0x%h was never completed", addr);
		end
	endtask

	task automatic write_reg(input axi_addr_t addr, input word_t data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check_resp("bresp", resp, RESP_OKAY);
	endtask

	task automatic read_reg(input axi_addr_t addr, output word_t data);
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check_resp("rresp", resp, RESP_OKAY);
	endtask

	// each chip answers with the word it got one frame before.
	task automatic run_transfer(input int nch, input int nw, input int div, input int tmo);
		word_t tx_q [$];
		word_t exp_q [$];
		word_t want;
		word_t got;
		int    polls;
		int    end_cycle;
		for (int c = 0; c < nch; c++) begin
			for (int w = 0; w < nw; w++) begin
				tx_q.push_back(rand_word());
				want = (w == 0) ? chip_hist[c] : tx_q[c * nw + w - 1];
				if (w == nw - 1) begin
					want[15:0] = {TAG_BYTE, 8'(c)};
				end
				exp_q.push_back(want);
			end
			chip_hist[c] = tx_q[c * nw + nw - 1];
		end
		write_reg(REG_TIMEOUT, word_t'(tmo));
		write_reg(REG_SCK, word_t'(div));
		write_reg(REG_CH_NUM, word_t'(nch));
		write_reg(REG_WORD_NUM, word_t'(nw));
		sel_mark = -1;
		foreach (tx_q[i]) begin
			write_reg(REG_TX_DATA, tx_q[i]);
		end
		polls = 0;
		do begin
			read_reg(REG_STATE, got);
			polls++;
		end while (api_state_e'(got[1:0]) == ST_IDLE && polls < POLL_LIMIT);
		do begin
			read_reg(REG_STATE, got);
			polls++;
		end while (api_state_e'(got[1:0]) != ST_IDLE && polls < POLL_LIMIT);
		end_cycle = cycle;
		check_state("state", api_state_e'(got[1:0]), ST_IDLE);
		check_word("load", word_t'(load), word_t'({API_NUM{1'b1}}));
		check_word("sck", word_t'(sck), '0);
		if (sel_mark < 0) begin
			errors++;
			$display("no chip was selected during the transfer");
		end else if (end_cycle - sel_mark < tmo) begin
			errors++;
			$display("idle after %0d cycles, sooner than the timeout of %0d", end_cycle - sel_mark, tmo);
		end
		read_reg(REG_RX_COUNT, got);
		check_word("rx_count", got, word_t'(exp_q.size()));
		foreach (exp_q[i]) begin
			read_reg(REG_RX_DATA, got);
			check_word("rx_data", got, exp_q[i]);
		end
		read_reg(REG_RX_COUNT, got);
		check_word("rx_count drained", got, '0);
	endtask

	task automatic test_reset_values();
		word_t got;
		check_word("load after reset", word_t'(load), word_t'({API_NUM{1'b1}}));
		check_word("sck after reset", word_t'(sck), '0);
		check_word("mosi after reset", word_t'(mosi), '0);
		read_reg(REG_STATE, got);
		check_state("state after reset", api_state_e'(got[1:0]), ST_IDLE);
		read_reg(REG_RX_COUNT, got);
		check_word("rx_count after reset", got, '0);
	endtask

	task automatic test_config_readback();
		word_t got;
		write_reg(REG_TIMEOUT, 32'h0ABC_DEF1);
		write_reg(REG_SCK, 32'h0000_005A);
		write_reg(REG_CH_NUM, 32'h0000_002B);
		write_reg(REG_WORD_NUM, 32'h0000_00C3);
		read_reg(REG_TIMEOUT, got);
		check_word("timeout", got, 32'h0ABC_DEF1);
		read_reg(REG_SCK, got);
		check_word("sck_div", got, 32'h0000_005A);
		read_reg(REG_CH_NUM, got);
		check_word("ch_num", got, 32'h0000_002B);
		read_reg(REG_WORD_NUM, got);
		check_word("word_num", got, 32'h0000_00C3);
	endtask

	task automatic test_error_responses();
		word_t      got;
		logic [1:0] resp;
		axi_read(REG_RX_DATA, got, resp);
		check_resp("rresp on empty rx", resp, RESP_SLVERR);
		check_word("rdata on empty rx", got, '0);
		axi_read(8'h20, got, resp);
		check_resp("rresp unmapped", resp, RESP_SLVERR);
		axi_write(8'h24, 32'h1234_5678, resp);
		check_resp("bresp unmapped", resp, RESP_SLVERR);
		axi_write(REG_RX_COUNT, 32'h0000_0005, resp); // read-only, so it is ignored.
		check_resp("bresp read-only", resp, RESP_OKAY);
		read_reg(REG_TIMEOUT, got);
		check_word("timeout after stray writes", got, 32'h0ABC_DEF1);
		read_reg(REG_CH_NUM, got);
		check_word("ch_num after stray writes", got, 32'h0000_002B);
	endtask

	initial begin
		rst     = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		foreach (chip_hist[i]) begin
			chip_hist[i] = '0;
		end
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		test_reset_values();
		test_config_readback();
		test_error_responses();
		run_transfer(T2_CH, T2_WN, T2_DIV, T2_TMO);
		run_transfer(T4_CH, T4_WN, T4_DIV, T4_TMO); // long timeout holds the sequencer busy.
		run_transfer(T6_CH, T6_WN, T6_DIV, T6_TMO);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- tb.f
hdl/api_pkg.sv
hdl/api_fifo.sv
hdl/api_timer.sv
hdl/api_phy.sv
hdl/api_regs.sv
hdl/api_ctrl.sv
hdl/api_top.sv
dv/api_chip_model.sv
dv/tb_api.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_api
FILELIST   := tb.f
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
